// File: axi_demux_top.f
verilog/axi_demux_pkg.sv
verilog/axi_demux_id_counters.sv
verilog/axi_demux_rr_arb.sv
verilog/axi_demux_write_ctrl.sv
verilog/axi_demux_read_ctrl.sv
verilog/axi_demux_top.sv
bench/axi_demux_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the axi demux testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module axi_demux_tb \
  -f axi_demux_top.f \
  -o axi_demux_sim

./obj_dir/axi_demux_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

// File: bench/axi_demux_tb.sv
// ------------------------------------------------
// testbench for the axi demux: master models,
// stimulus, scoreboard, assertions and reporting
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_demux_tb;
  import axi_demux_pkg::*;

  localparam int unsigned NumPorts = 3;
  localparam int          Timeout  = 2000;

  logic      clk_i    = 1'b0;
  logic      rst_n_i  = 1'b0;
  // slave side drive signals, packed into slv_req below
  aw_chan_t  aw       = '0;
  ar_chan_t  ar       = '0;
  w_chan_t   w        = '0;
  logic      aw_valid = 1'b0;
  logic      w_valid  = 1'b0;
  logic      ar_valid = 1'b0;
  logic      b_ready  = 1'b0;
  logic      r_ready  = 1'b0;
  sel_t      aw_sel   = '0;
  sel_t      ar_sel   = '0;
  axi_req_t  slv_req;
  axi_resp_t slv_resp;
  axi_req_t  mst_reqs [NumPorts];
  axi_resp_t mst_resps [NumPorts] = '{default: '0};

  int   seed     = 32'ha809;
  int   err_cnt  = 0;
  int   pass_cnt = 0;
  int   fail_cnt = 0;
  logic b_stall  = 1'b0;
  logic rand_rdy = 1'b0;
  // scoreboard state, ids 0..3 so full id equals low bits
  int   wr_out [4] = '{default: 0};
  int   rd_out [4] = '{default: 0};
  int   r_beat [4] = '{default: 0};
  sel_t wr_port [4];
  sel_t rd_port [4];
  sel_t wexp_q [$];

  assign slv_req = '{aw: aw, aw_valid: aw_valid, w: w, w_valid: w_valid, b_ready: b_ready,
                     ar: ar, ar_valid: ar_valid, r_ready: r_ready};

  always #50 clk_i = ~clk_i;

  axi_demux_top #(
    .NumMstPorts ( NumPorts ),
    .IdLookBits  ( 2        ),
    .CntWidth    ( 3        )
  ) axi_demux_top_inst (
    .clk_i           ( clk_i     ),
    .rst_n_i         ( rst_n_i   ),
    .slv_req_i       ( slv_req   ),
    .slv_aw_select_i ( aw_sel    ),
    .slv_ar_select_i ( ar_sel    ),
    .slv_resp_o      ( slv_resp  ),
    .mst_reqs_o      ( mst_reqs  ),
    .mst_resps_i     ( mst_resps )
  );

  task automatic report_error(input string name, input int exp_v, input int act_v);
    $display("** Error: %s expected %0h actual %0h", name, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // ------------------------------------------------
  // master models, in-order b and r per port
  // ------------------------------------------------
  for (genvar p = 0; p < NumPorts; p++) begin : gen_mst
    logic [3:0] awq [$];
    logic [3:0] arq [$];
    int         wlast = 0;
    int         rbeat = 0;
    axi_resp_t  nxt   = '0;

    // handshakes are sampled mid-cycle where everything is settled
    always @(negedge clk_i) begin
      if (rst_n_i) begin
        if (mst_reqs[p].aw_valid && mst_resps[p].aw_ready) awq.push_back(mst_reqs[p].aw.id);
        if (mst_reqs[p].w_valid && mst_resps[p].w_ready && mst_reqs[p].w.last) wlast++;
        if (mst_reqs[p].ar_valid && mst_resps[p].ar_ready) arq.push_back(mst_reqs[p].ar.id);
        if (mst_resps[p].b_valid && mst_reqs[p].b_ready) begin
          void'(awq.pop_front());
          wlast--;
        end
        if (mst_resps[p].r_valid && mst_reqs[p].r_ready) begin
          if (mst_resps[p].r.last) begin
            void'(arq.pop_front());
            rbeat = 0;
          end else begin
            rbeat++;
          end
        end
        nxt          = mst_resps[p];
        nxt.aw_ready = (($random(seed) & 3) != 0);
        nxt.w_ready  = (($random(seed) & 3) != 0);
        nxt.ar_ready = (($random(seed) & 3) != 0);
        // a waiting response keeps its payload
        if (!(mst_resps[p].b_valid && !mst_reqs[p].b_ready)) begin
          nxt.b_valid = !b_stall && awq.size() > 0 && wlast > 0 && (($random(seed) & 1) == 1);
          nxt.b.id    = (awq.size() > 0) ? awq[0] : 4'h0;
          nxt.b.resp  = 2'(p);
        end
        if (!(mst_resps[p].r_valid && !mst_reqs[p].r_ready)) begin
          nxt.r_valid = arq.size() > 0 && (($random(seed) & 1) == 1);
          if (arq.size() > 0) begin
            nxt.r.id   = arq[0];
            nxt.r.data = {24'h0, 2'(p), arq[0][1:0], 4'(rbeat)};
            nxt.r.resp = 2'(p);
            nxt.r.last = (rbeat == int'(arq[0][1:0]));
          end
        end
      end
    end

    always @(posedge clk_i) begin
      mst_resps[p] <= rst_n_i ? nxt : '0;
    end

    // only the selected port sees aw or ar, payload unchanged
    a_aw_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_reqs[p].aw_valid |-> (aw_sel == sel_t'(p) && mst_reqs[p].aw == slv_req.aw))
      else report_error("aw route", p, aw_sel);
    a_ar_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_reqs[p].ar_valid |-> (ar_sel == sel_t'(p) && mst_reqs[p].ar == slv_req.ar))
      else report_error("ar route", p, ar_sel);
    // w beats reach the port unchanged
    a_w_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_reqs[p].w_valid |-> (mst_reqs[p].w == slv_req.w))
      else report_error("w payload", slv_req.w.data, mst_reqs[p].w.data);
    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_reqs[p].aw_valid && !mst_resps[p].aw_ready |=> mst_reqs[p].aw_valid)
      else report_error("aw valid hold", 1, 0);
    a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_reqs[p].ar_valid && !mst_resps[p].ar_ready |=> mst_reqs[p].ar_valid)
      else report_error("ar valid hold", 1, 0);
  end

  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_resp.b_valid && !b_ready |=> slv_resp.b_valid && $stable(slv_resp.b))
    else report_error("b stable", 1, 0);
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_resp.r_valid && !r_ready |=> slv_resp.r_valid && $stable(slv_resp.r))
    else report_error("r stable", 1, 0);

  // ------------------------------------------------
  // scoreboard at the slave port
  // ------------------------------------------------
  always @(negedge clk_i) begin
    logic [1:0] id;
    int         w_port;
    int         max_out;
    if (rst_n_i) begin
      max_out = 0;
      for (int i = 0; i < 4; i++) begin
        if (wr_out[i] > max_out) max_out = wr_out[i];
      end
      if (aw_valid && slv_resp.aw_ready) begin
        id = aw.id[1:0];
        assert (wr_out[id] == 0 || wr_port[id] == aw_sel)
          else report_error("aw same id port", wr_port[id], aw_sel);
        assert (wexp_q.size() == 0 || wexp_q[$] == aw_sel)
          else report_error("aw while w open", wexp_q[$], aw_sel);
        assert (max_out < 7) else report_error("aw capacity", 6, max_out);
        wr_out[id]++;
        wr_port[id] = aw_sel;
        wexp_q.push_back(aw_sel);
      end
      if (w_valid && slv_resp.w_ready) begin
        w_port = -1;
        for (int p = 0; p < NumPorts; p++) begin
          if (mst_reqs[p].w_valid) w_port = p;
        end
        assert (wexp_q.size() > 0 && w_port == int'(wexp_q[0]))
          else report_error("w route", (wexp_q.size() > 0) ? wexp_q[0] : 3, w_port);
        if (w.last && wexp_q.size() > 0) void'(wexp_q.pop_front());
      end
      if (ar_valid && slv_resp.ar_ready) begin
        id = ar.id[1:0];
        assert (rd_out[id] == 0 || rd_port[id] == ar_sel)
          else report_error("ar same id port", rd_port[id], ar_sel);
        rd_out[id]++;
        rd_port[id] = ar_sel;
      end
      if (slv_resp.b_valid && b_ready) begin
        id = slv_resp.b.id[1:0];
        assert (wr_out[id] > 0 && slv_resp.b.resp == wr_port[id])
          else report_error("b response", wr_port[id], slv_resp.b.resp);
        if (wr_out[id] > 0) wr_out[id]--;
      end
      if (slv_resp.r_valid && r_ready) begin
        id = slv_resp.r.id[1:0];
        assert (rd_out[id] > 0 &&
                slv_resp.r.data == {24'h0, rd_port[id], id, 4'(r_beat[id])})
          else report_error("r data", {24'h0, rd_port[id], id, 4'(r_beat[id])},
                            slv_resp.r.data);
        assert (slv_resp.r.last == (r_beat[id] == int'(id)))
          else report_error("r last", (r_beat[id] == int'(id)), slv_resp.r.last);
        if (slv_resp.r.last) begin
          r_beat[id] = 0;
          if (rd_out[id] > 0) rd_out[id]--;
        end else begin
          r_beat[id]++;
        end
      end
    end
  end

  // slave ready for responses, random during the stress test
  always @(posedge clk_i) begin
    b_ready <= rand_rdy ? (($random(seed) & 1) == 1) : 1'b1;
    r_ready <= rand_rdy ? (($random(seed) & 1) == 1) : 1'b1;
  end

  // ------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------
  task automatic send_aw(input logic [1:0] id, input sel_t sel);
    int t;
    t = 0;
    @(posedge clk_i);
    aw_valid <= 1'b1;
    aw       <= '{id: 4'(id), addr: 16'($random(seed)), len: 8'd0};
    aw_sel   <= sel;
    @(negedge clk_i);
    while (!slv_resp.aw_ready) begin
      t++;
      if (t > Timeout) abort_on_timeout("aw ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    aw_valid <= 1'b0;
  endtask

  task automatic send_w();
    int t;
    t = 0;
    @(posedge clk_i);
    w_valid <= 1'b1;
    w       <= '{data: 32'($random(seed)), last: 1'b1};
    @(negedge clk_i);
    while (!slv_resp.w_ready) begin
      t++;
      if (t > Timeout) abort_on_timeout("w ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    w_valid <= 1'b0;
  endtask

  // read bursts are id+1 beats long
  task automatic send_ar(input logic [1:0] id, input sel_t sel);
    int t;
    t = 0;
    @(posedge clk_i);
    ar_valid <= 1'b1;
    ar       <= '{id: 4'(id), addr: 16'($random(seed)), len: 8'(id)};
    ar_sel   <= sel;
    @(negedge clk_i);
    while (!slv_resp.ar_ready) begin
      t++;
      if (t > Timeout) abort_on_timeout("ar ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    @(negedge clk_i);
    while ((wr_out.sum() + rd_out.sum()) != 0 || wexp_q.size() != 0) begin
      t++;
      if (t > Timeout) abort_on_timeout("outstanding responses");
      @(negedge clk_i);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------
  initial begin
    int e;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    e = err_cnt;
    @(negedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      assert (!mst_reqs[p].aw_valid && !mst_reqs[p].w_valid && !mst_reqs[p].ar_valid)
        else report_error("reset master valid", 0, p);
    end
    assert (!slv_resp.b_valid && !slv_resp.r_valid) else report_error("reset slave valid", 0, 1);
    end_test("reset", e);

    e = err_cnt;
    for (int p = 0; p < NumPorts; p++) begin
      send_aw(2'(p), sel_t'(p));
      send_w();
      send_ar(2'(p), sel_t'(p));
    end
    wait_drain();
    end_test("routing", e);

    e = err_cnt;
    send_aw(2'd0, sel_t'(0));
    fork
      send_aw(2'd1, sel_t'(1));
      begin
        repeat (5) @(posedge clk_i);
        send_w();
        send_w();
      end
    join
    wait_drain();
    end_test("w order", e);

    e = err_cnt;
    send_ar(2'd1, sel_t'(0));
    send_ar(2'd1, sel_t'(2));
    send_aw(2'd3, sel_t'(1));
    send_w();
    send_aw(2'd3, sel_t'(2));
    send_w();
    wait_drain();
    end_test("same id order", e);

    e = err_cnt;
    rand_rdy = 1'b1;
    fork
      for (int i = 0; i < 20; i++) begin
        send_aw(2'($random(seed)), sel_t'($unsigned($random(seed)) % NumPorts));
        send_w();
      end
      for (int i = 0; i < 20; i++) begin
        send_ar(2'($random(seed)), sel_t'($unsigned($random(seed)) % NumPorts));
      end
    join
    wait_drain();
    rand_rdy = 1'b0;
    end_test("responses", e);

    e = err_cnt;
    @(posedge clk_i);
    b_stall = 1'b1;
    for (int i = 0; i < 7; i++) begin
      send_aw(2'd2, sel_t'(0));
      send_w();
    end
    fork
      send_aw(2'd2, sel_t'(0));
      begin
        repeat (20) @(negedge clk_i);
        assert (wr_out[2] == 7) else report_error("capacity hold", 7, wr_out[2]);
        @(posedge clk_i);
        b_stall = 1'b0;
      end
    join
    send_w();
    wait_drain();
    end_test("capacity", e);

    $display("tests passed %0d failed %0d errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/axi_demux_top.sv
// ------------------------------------------------
// axi one-to-many demux, top level wiring of the
// channel control, id counters and response arbiters
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_demux_top #(
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned IdLookBits  = 2,
  parameter int unsigned CntWidth    = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // slave port
  input  axi_demux_pkg::axi_req_t  slv_req_i,
  input  axi_demux_pkg::sel_t      slv_aw_select_i,
  input  axi_demux_pkg::sel_t      slv_ar_select_i,
  output axi_demux_pkg::axi_resp_t slv_resp_o,
  // master ports
  output axi_demux_pkg::axi_req_t  mst_reqs_o [NumMstPorts],
  input  axi_demux_pkg::axi_resp_t mst_resps_i [NumMstPorts]
);
  import axi_demux_pkg::*;

  // per-port handshake vectors
  logic [NumMstPorts-1:0] mst_aw_valid, mst_aw_ready;
  logic [NumMstPorts-1:0] mst_w_valid, mst_w_ready;
  logic [NumMstPorts-1:0] mst_ar_valid, mst_ar_ready;
  logic [NumMstPorts-1:0] mst_b_valid, mst_b_ready;
  logic [NumMstPorts-1:0] mst_r_valid, mst_r_ready;
  b_chan_t                mst_b [NumMstPorts];
  r_chan_t                mst_r [NumMstPorts];

  // id counter lookups
  sel_t aw_lookup_sel, ar_lookup_sel;
  logic aw_occupied, ar_occupied;
  logic aw_cnt_full, ar_cnt_full;
  logic aw_push, ar_push;

  // merged responses toward the slave
  b_chan_t slv_b;
  r_chan_t slv_r;
  logic    slv_b_valid, slv_r_valid;

  // ------------------------------------------------
  // write path
  // ------------------------------------------------
  axi_demux_write_ctrl #(
    .NumMstPorts ( NumMstPorts ),
    .CntWidth    ( CntWidth    )
  ) write_ctrl_inst (
    .clk_i             ( clk_i                  ),
    .rst_n_i           ( rst_n_i                ),
    .slv_aw_valid_i    ( slv_req_i.aw_valid     ),
    .slv_aw_select_i   ( slv_aw_select_i        ),
    .slv_aw_ready_o    ( slv_resp_o.aw_ready    ),
    .mst_aw_valid_o    ( mst_aw_valid           ),
    .mst_aw_ready_i    ( mst_aw_ready           ),
    .aw_push_o         ( aw_push                ),
    .slv_w_i           ( slv_req_i.w            ),
    .slv_w_valid_i     ( slv_req_i.w_valid      ),
    .slv_w_ready_o     ( slv_resp_o.w_ready     ),
    .mst_w_valid_o     ( mst_w_valid            ),
    .mst_w_ready_i     ( mst_w_ready            ),
    .lookup_select_i   ( aw_lookup_sel          ),
    .lookup_occupied_i ( aw_occupied            ),
    .cnt_full_i        ( aw_cnt_full            )
  );

  // b pops the write counters once the slave takes it
  axi_demux_id_counters #(
    .IdLookBits ( IdLookBits ),
    .CntWidth   ( CntWidth   )
  ) aw_id_counters_inst (
    .clk_i             ( clk_i                                   ),
    .rst_n_i           ( rst_n_i                                 ),
    .lookup_id_i       ( slv_req_i.aw.id[IdLookBits-1:0]         ),
    .push_id_i         ( slv_req_i.aw.id[IdLookBits-1:0]         ),
    .pop_id_i          ( slv_b.id[IdLookBits-1:0]                ),
    .push_select_i     ( slv_aw_select_i                         ),
    .push_i            ( aw_push                                 ),
    .pop_i             ( slv_b_valid & slv_req_i.b_ready         ),
    .lookup_select_o   ( aw_lookup_sel                           ),
    .lookup_occupied_o ( aw_occupied                             ),
    .full_o            ( aw_cnt_full                             )
  );

  axi_demux_rr_arb #(
    .NumIn     ( NumMstPorts ),
    .payload_t ( b_chan_t    )
  ) b_arb_inst (
    .clk_i   ( clk_i             ),
    .rst_n_i ( rst_n_i           ),
    .req_i   ( mst_b_valid       ),
    .data_i  ( mst_b             ),
    .gnt_o   ( mst_b_ready       ),
    .req_o   ( slv_b_valid       ),
    .data_o  ( slv_b             ),
    .gnt_i   ( slv_req_i.b_ready )
  );

  // ------------------------------------------------
  // read path
  // ------------------------------------------------
  axi_demux_read_ctrl #(
    .NumMstPorts ( NumMstPorts )
  ) read_ctrl_inst (
    .clk_i             ( clk_i               ),
    .rst_n_i           ( rst_n_i             ),
    .slv_ar_valid_i    ( slv_req_i.ar_valid  ),
    .slv_ar_select_i   ( slv_ar_select_i     ),
    .mst_ar_ready_i    ( mst_ar_ready        ),
    .lookup_select_i   ( ar_lookup_sel       ),
    .lookup_occupied_i ( ar_occupied         ),
    .cnt_full_i        ( ar_cnt_full         ),
    .slv_ar_ready_o    ( slv_resp_o.ar_ready ),
    .mst_ar_valid_o    ( mst_ar_valid        ),
    .ar_push_o         ( ar_push             )
  );

  // only the last beat of a read burst pops
  axi_demux_id_counters #(
    .IdLookBits ( IdLookBits ),
    .CntWidth   ( CntWidth   )
  ) ar_id_counters_inst (
    .clk_i             ( clk_i                                      ),
    .rst_n_i           ( rst_n_i                                    ),
    .lookup_id_i       ( slv_req_i.ar.id[IdLookBits-1:0]            ),
    .push_id_i         ( slv_req_i.ar.id[IdLookBits-1:0]            ),
    .pop_id_i          ( slv_r.id[IdLookBits-1:0]                   ),
    .push_select_i     ( slv_ar_select_i                            ),
    .push_i            ( ar_push                                    ),
    .pop_i             ( slv_r_valid & slv_req_i.r_ready & slv_r.last ),
    .lookup_select_o   ( ar_lookup_sel                              ),
    .lookup_occupied_o ( ar_occupied                                ),
    .full_o            ( ar_cnt_full                                )
  );

  axi_demux_rr_arb #(
    .NumIn     ( NumMstPorts ),
    .payload_t ( r_chan_t    )
  ) r_arb_inst (
    .clk_i   ( clk_i             ),
    .rst_n_i ( rst_n_i           ),
    .req_i   ( mst_r_valid       ),
    .data_i  ( mst_r             ),
    .gnt_o   ( mst_r_ready       ),
    .req_o   ( slv_r_valid       ),
    .data_o  ( slv_r             ),
    .gnt_i   ( slv_req_i.r_ready )
  );

  assign slv_resp_o.b       = slv_b;
  assign slv_resp_o.b_valid = slv_b_valid;
  assign slv_resp_o.r       = slv_r;
  assign slv_resp_o.r_valid = slv_r_valid;

  // ------------------------------------------------
  // per-port bundles
  // ------------------------------------------------
  for (genvar i = 0; i < NumMstPorts; i++) begin : gen_port
    // payloads fan out to every port, valids are steered
    assign mst_reqs_o[i].aw       = slv_req_i.aw;
    assign mst_reqs_o[i].aw_valid = mst_aw_valid[i];
    assign mst_reqs_o[i].w        = slv_req_i.w;
    assign mst_reqs_o[i].w_valid  = mst_w_valid[i];
    assign mst_reqs_o[i].b_ready  = mst_b_ready[i];
    assign mst_reqs_o[i].ar       = slv_req_i.ar;
    assign mst_reqs_o[i].ar_valid = mst_ar_valid[i];
    assign mst_reqs_o[i].r_ready  = mst_r_ready[i];
    // unpack the response side
    assign mst_aw_ready[i] = mst_resps_i[i].aw_ready;
    assign mst_w_ready[i]  = mst_resps_i[i].w_ready;
    assign mst_ar_ready[i] = mst_resps_i[i].ar_ready;
    assign mst_b_valid[i]  = mst_resps_i[i].b_valid;
    assign mst_b[i]        = mst_resps_i[i].b;
    assign mst_r_valid[i]  = mst_resps_i[i].r_valid;
    assign mst_r[i]        = mst_resps_i[i].r;
  end

endmodule

`default_nettype wire

// File: verilog/axi_demux_read_ctrl.sv
// ------------------------------------------------
// ar admission and valid lock
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_demux_read_ctrl #(
  parameter int unsigned NumMstPorts = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   slv_ar_valid_i,
  input  axi_demux_pkg::sel_t    slv_ar_select_i,
  input  logic [NumMstPorts-1:0] mst_ar_ready_i,
  // ar id counter lookup
  input  axi_demux_pkg::sel_t    lookup_select_i,
  input  logic                   lookup_occupied_i,
  input  logic                   cnt_full_i,
  output logic                   slv_ar_ready_o,
  output logic [NumMstPorts-1:0] mst_ar_valid_o,
  output logic                   ar_push_o
);
  import axi_demux_pkg::*;

  logic lock_q;
  logic ar_admit;
  logic ar_valid;
  logic ar_ready_sel;

  // same id stays on one port while in flight
  assign ar_admit = slv_ar_valid_i && !cnt_full_i &&
                    (!lookup_occupied_i || (lookup_select_i == slv_ar_select_i));

  assign ar_valid       = lock_q | ar_admit;
  assign slv_ar_ready_o = ar_valid & ar_ready_sel;
  // reads count only once the master takes the beat
  assign ar_push_o      = ar_valid & ar_ready_sel;

  // only the selected port sees valid
  always_comb begin
    ar_ready_sel   = 1'b0;
    mst_ar_valid_o = '0;
    for (int i = 0; i < NumMstPorts; i++) begin
      if (slv_ar_select_i == sel_t'(i)) begin
        ar_ready_sel      = mst_ar_ready_i[i];
        mst_ar_valid_o[i] = ar_valid;
      end
    end
  end

  // hold valid through counter changes while stalled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else if (lock_q && ar_ready_sel) begin
      lock_q <= 1'b0;
    end else if (ar_admit && !lock_q && !ar_ready_sel) begin
      lock_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_demux_write_ctrl.sv
// ------------------------------------------------
// aw admission with valid lock, open-w counter and
// w steering toward the stored target port
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_demux_write_ctrl #(
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned CntWidth    = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // aw channel
  input  logic                   slv_aw_valid_i,
  input  axi_demux_pkg::sel_t    slv_aw_select_i,
  output logic                   slv_aw_ready_o,
  output logic [NumMstPorts-1:0] mst_aw_valid_o,
  input  logic [NumMstPorts-1:0] mst_aw_ready_i,
  output logic                   aw_push_o,
  // w channel
  input  axi_demux_pkg::w_chan_t slv_w_i,
  input  logic                   slv_w_valid_i,
  output logic                   slv_w_ready_o,
  output logic [NumMstPorts-1:0] mst_w_valid_o,
  input  logic [NumMstPorts-1:0] mst_w_ready_i,
  // aw id counter lookup
  input  axi_demux_pkg::sel_t    lookup_select_i,
  input  logic                   lookup_occupied_i,
  input  logic                   cnt_full_i
);
  import axi_demux_pkg::*;

  logic                lock_q;
  logic [CntWidth-1:0] w_open_q;
  sel_t                w_select_q;
  sel_t                w_select;
  logic                w_select_valid;
  logic                w_pop;
  logic                aw_admit;
  logic                aw_valid;
  logic                aw_ready_sel;

  // ------------------------------------------------
  // aw admission
  // ------------------------------------------------
  // open w bursts must all go to the same port, and
  // an id already in flight must stay on its port
  assign aw_admit = slv_aw_valid_i && !(&w_open_q) && !cnt_full_i &&
                    ((w_open_q == '0) || (w_select_q == slv_aw_select_i)) &&
                    (!lookup_occupied_i || (lookup_select_i == slv_aw_select_i));

  // the lock keeps valid up until the master takes it
  assign aw_valid       = lock_q | aw_admit;
  // push happens once, on the first cycle of valid
  assign aw_push_o      = aw_admit & ~lock_q;
  assign slv_aw_ready_o = aw_valid & aw_ready_sel;

  always_comb begin
    aw_ready_sel   = 1'b0;
    mst_aw_valid_o = '0;
    for (int i = 0; i < NumMstPorts; i++) begin
      if (slv_aw_select_i == sel_t'(i)) begin
        aw_ready_sel      = mst_aw_ready_i[i];
        mst_aw_valid_o[i] = aw_valid;
      end
    end
  end

  // ------------------------------------------------
  // w steering
  // ------------------------------------------------
  // target pushed this cycle is usable right away
  assign w_select       = (w_open_q != '0) ? w_select_q : slv_aw_select_i;
  assign w_select_valid = aw_push_o | (w_open_q != '0);

  always_comb begin
    mst_w_valid_o = '0;
    slv_w_ready_o = 1'b0;
    w_pop         = 1'b0;
    for (int i = 0; i < NumMstPorts; i++) begin
      if (w_select_valid && (w_select == sel_t'(i))) begin
        mst_w_valid_o[i] = slv_w_valid_i;
        slv_w_ready_o    = mst_w_ready_i[i];
        // burst closes on an accepted last beat
        w_pop            = slv_w_valid_i & mst_w_ready_i[i] & slv_w_i.last;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      w_open_q   <= '0;
      w_select_q <= '0;
    end else begin
      // lock on a stalled first cycle, release on handshake
      if (lock_q && aw_ready_sel) begin
        lock_q <= 1'b0;
      end else if (aw_push_o && !aw_ready_sel) begin
        lock_q <= 1'b1;
      end
      // open-w count, push and pop cancel
      if (aw_push_o && !w_pop) begin
        w_open_q <= w_open_q + CntWidth'(1);
      end else if (w_pop && !aw_push_o) begin
        w_open_q <= w_open_q - CntWidth'(1);
      end
      if (aw_push_o) begin
        w_select_q <= slv_aw_select_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_demux_rr_arb.sv
// ------------------------------------------------
// round-robin valid/ready arbiter with grant hold
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_demux_rr_arb #(
  parameter int unsigned NumIn     = 3,
  parameter type         payload_t = logic
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // inbound side
  input  logic [NumIn-1:0] req_i,
  input  payload_t         data_i [NumIn],
  output logic [NumIn-1:0] gnt_o,
  // outbound side
  output logic             req_o,
  output payload_t         data_o,
  input  logic             gnt_i
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxWidth-1:0] last_q;
  logic [IdxWidth-1:0] hold_idx_q;
  logic [IdxWidth-1:0] rr_idx;
  logic [IdxWidth-1:0] sel_idx;
  logic                hold_q;

  // search starts one past the last granted input
  always_comb begin
    int unsigned cand;
    logic        found;
    cand   = 0;
    found  = 1'b0;
    rr_idx = last_q;
    for (int unsigned k = 1; k <= NumIn; k++) begin
      cand = (32'(last_q) + k) % NumIn;
      if (!found && req_i[cand]) begin
        found  = 1'b1;
        rr_idx = IdxWidth'(cand);
      end
    end
  end

  // a waiting beat keeps its input until granted
  assign sel_idx = hold_q ? hold_idx_q : rr_idx;
  assign req_o   = req_i[sel_idx];
  assign data_o  = data_i[sel_idx];

  always_comb begin
    gnt_o = '0;
    for (int unsigned i = 0; i < NumIn; i++) begin
      gnt_o[i] = gnt_i && (sel_idx == IdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // first search begins at input 0
      last_q     <= IdxWidth'(NumIn - 1);
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= req_o & ~gnt_i;
      hold_idx_q <= sel_idx;
      if (req_o && gnt_i) begin
        last_q <= sel_idx;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_demux_id_counters.sv
// ------------------------------------------------
// in-flight counters and remembered ports per low id
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_demux_id_counters #(
  parameter int unsigned IdLookBits = 2,
  parameter int unsigned CntWidth   = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [IdLookBits-1:0] lookup_id_i,
  input  logic [IdLookBits-1:0] push_id_i,
  input  logic [IdLookBits-1:0] pop_id_i,
  input  axi_demux_pkg::sel_t   push_select_i,
  input  logic                  push_i,
  input  logic                  pop_i,
  output axi_demux_pkg::sel_t   lookup_select_o,
  output logic                  lookup_occupied_o,
  output logic                  full_o
);
  import axi_demux_pkg::*;

  // one entry per value of the low id bits
  localparam int unsigned NumCnt = 2 ** IdLookBits;

  logic [CntWidth-1:0] cnt_q [NumCnt];
  sel_t                sel_q [NumCnt];
  logic [NumCnt-1:0]   cnt_full;

  // lookup of the entry for the id at the slave port
  assign lookup_select_o   = sel_q[lookup_id_i];
  assign lookup_occupied_o = (cnt_q[lookup_id_i] != '0);
  // any saturated counter blocks new pushes
  assign full_o            = |cnt_full;

  for (genvar i = 0; i < NumCnt; i++) begin : gen_cnt
    logic push_en;
    logic pop_en;

    assign push_en     = push_i && (push_id_i == IdLookBits'(i));
    assign pop_en      = pop_i && (pop_id_i == IdLookBits'(i));
    assign cnt_full[i] = &cnt_q[i];

    // up/down count, push and pop on one entry cancel
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (push_en && !pop_en) begin
        cnt_q[i] <= cnt_q[i] + CntWidth'(1);
      end else if (pop_en && !push_en) begin
        cnt_q[i] <= cnt_q[i] - CntWidth'(1);
      end
    end

    // port of the latest push, only read while occupied
    always_ff @(posedge clk_i) begin
      if (push_en) begin
        sel_q[i] <= push_select_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_demux_pkg.sv
// ------------------------------------------------
// axi widths, channel structs, request and response
// bundles and the master-port select type
// ------------------------------------------------
`default_nettype none

package axi_demux_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------
  localparam int unsigned ID_WIDTH      = 4;
  localparam int unsigned ADDR_WIDTH    = 16;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned LEN_WIDTH     = 8;
  // upper limit on the number of master ports
  localparam int unsigned MAX_MST_PORTS = 4;
  localparam int unsigned SEL_WIDTH     = $clog2(MAX_MST_PORTS);

  // master-port index
  typedef logic [SEL_WIDTH-1:0] sel_t;

  // ------------------------------------------------
  // channel payloads
  // ------------------------------------------------
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } aw_chan_t;

  // read address uses the write address layout
  typedef aw_chan_t ar_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // ------------------------------------------------
  // port bundles
  // ------------------------------------------------
  // manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // subordinate to manager direction
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_resp_t;

endpackage

`default_nettype wire
